//--- mem_test_pkg.sv
package mem_test_pkg;

  // pin widths of one SRAM chip.
  localparam int SRAM_ADDR_W = 18;
  localparam int SRAM_DATA_W = 8;

  // chips sit side by side, each one holds one byte lane of a word.
  localparam int NUM_CHIPS = 2;
  localparam int WORD_W = NUM_CHIPS * SRAM_DATA_W;

  // byte address, so one bit wider than the word index.
  localparam int AXI_ADDR_W = 19;

  typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;  // chip address, equal to the word index.
  typedef logic [SRAM_DATA_W-1:0] sram_data_t;  // one chip's byte.
  typedef logic [WORD_W-1:0]      word_t;       // striped word.
  typedef logic [AXI_ADDR_W-1:0]  axi_addr_t;   // AXI byte address.

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_WR_STROBE,
    CTRL_RD_WAIT,
    CTRL_FINISH
  } ctrl_state_t;

  typedef enum logic [2:0] {
    SEQ_WR_ISSUE,
    SEQ_WR_RESP,
    SEQ_RD_ISSUE,
    SEQ_RD_DATA,
    SEQ_REPORT
  } seq_state_t;

  // test pattern for one word. the odd multiplier spreads neighbouring
  // indices over all bits, and the pass term moves every word each pass.
  function automatic word_t pattern_word(input sram_addr_t idx, input logic [7:0] pass_idx);
    logic [31:0] mix;
    mix = 32'(idx) * 32'h9E37 + 32'(pass_idx) * 32'h3C5A;
    return mix[WORD_W-1:0];
  endfunction

endpackage

//--- sram_chip_ctrl.sv
`timescale 1ns/1ns

module sram_chip_ctrl (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic                          start,
  input  logic                          write,
  input  mem_test_pkg::sram_addr_t      addr,
  input  mem_test_pkg::sram_data_t      wdata,
  output mem_test_pkg::sram_data_t      rdata,
  output logic                          done,
  output logic                          sram_oe_n,
  output logic                          sram_we_n,
  output mem_test_pkg::sram_addr_t      sram_addr,
  inout  wire mem_test_pkg::sram_data_t sram_data
);
  import mem_test_pkg::*;

  ctrl_state_t state;
  sram_addr_t  addr_q;
  sram_data_t  wdata_q;
  logic        drive;  // high while this side owns the data bus.

  // a write is one cycle of we_n low and one cycle of hold with we_n high.
  // a read keeps oe_n low for two cycles so the chip output can settle.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state     <= CTRL_IDLE;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      drive     <= 1'b0;
    end else begin
      case (state)
        CTRL_IDLE: begin
          if (start) begin
            state     <= write ? CTRL_WR_STROBE : CTRL_RD_WAIT;
            sram_we_n <= !write;
            sram_oe_n <= write;
            drive     <= write;
          end
        end
        CTRL_WR_STROBE: begin
          state     <= CTRL_FINISH;
          sram_we_n <= 1'b1;  // rising we_n latches the byte, data stays for hold.
        end
        CTRL_RD_WAIT: begin
          state <= CTRL_FINISH;
        end
        CTRL_FINISH: begin
          state     <= CTRL_IDLE;
          sram_oe_n <= 1'b1;
          drive     <= 1'b0;
        end
        default: begin
          state <= CTRL_IDLE;
        end
      endcase
    end
  end

  // address and write byte are held for the whole access.
  always_ff @(posedge CLK) begin
    if (start && state == CTRL_IDLE) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  assign sram_addr = addr_q;
  assign sram_data = drive ? wdata_q : 'z;
  assign done      = (state == CTRL_FINISH);

  // the bus value is taken by the requester on the edge that ends the done
  // cycle, which is the end of the second read cycle.
  assign rdata = sram_data;

  // both strobes low would let the chip and this side fight over the bus.
  assert property (@(posedge CLK) disable iff (!rst_n) sram_we_n || sram_oe_n)
    else $error("we_n and oe_n low together");

  // the requester must wait for done before the next start.
  assert property (@(posedge CLK) disable iff (!rst_n) start |-> state == CTRL_IDLE)
    else $error("start while an access is in progress");

endmodule

//--- sram_stripe_axil.sv
`timescale 1ns/1ns

module sram_stripe_axil (
  input  logic                     CLK,
  input  logic                     rst_n,

  // AXI4-Lite slave
  input  logic                     awvalid,
  output logic                     awready,
  input  mem_test_pkg::axi_addr_t  awaddr,
  input  logic                     wvalid,
  output logic                     wready,
  input  mem_test_pkg::word_t      wdata,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic                     arvalid,
  output logic                     arready,
  input  mem_test_pkg::axi_addr_t  araddr,
  output logic                     rvalid,
  input  logic                     rready,
  output mem_test_pkg::word_t      rdata,

  // chip A controller, low byte
  output logic                     a_start,
  output logic                     a_write,
  output mem_test_pkg::sram_addr_t a_addr,
  output mem_test_pkg::sram_data_t a_wdata,
  input  mem_test_pkg::sram_data_t a_rdata,
  input  logic                     a_done,

  // chip B controller, high byte
  output logic                     b_start,
  output logic                     b_write,
  output mem_test_pkg::sram_addr_t b_addr,
  output mem_test_pkg::sram_data_t b_wdata,
  input  mem_test_pkg::sram_data_t b_rdata,
  input  logic                     b_done
);
  import mem_test_pkg::*;

  logic       busy;  // set from request accept until the response is taken.
  logic       start_q;
  logic       write_q;
  sram_addr_t addr_q;
  word_t      wdata_q;
  logic       a_done_q;
  logic       b_done_q;
  logic       both_done;
  logic       aw_fire;
  logic       ar_fire;

  // write address and data are taken together, and writes win over reads.
  assign awready = !busy && awvalid && wvalid;
  assign wready  = awready;
  assign arready = !busy && arvalid && !(awvalid && wvalid);

  assign aw_fire = awvalid && awready;
  assign ar_fire = arvalid && arready;

  // a done seen in an earlier cycle counts as well as one seen now.
  assign both_done = (a_done || a_done_q) && (b_done || b_done_q);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      start_q  <= 1'b0;
      write_q  <= 1'b0;
      a_done_q <= 1'b0;
      b_done_q <= 1'b0;
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      start_q <= aw_fire || ar_fire;  // one cycle start to both chips.
      if (aw_fire || ar_fire) begin
        busy    <= 1'b1;
        write_q <= aw_fire;
      end

      if (both_done) begin
        a_done_q <= 1'b0;
        b_done_q <= 1'b0;
        bvalid   <= write_q;
        rvalid   <= !write_q;
      end else begin
        if (a_done) a_done_q <= 1'b1;
        if (b_done) b_done_q <= 1'b1;
      end

      if ((bvalid && bready) || (rvalid && rready)) begin
        bvalid <= 1'b0;
        rvalid <= 1'b0;
        busy   <= 1'b0;
      end
    end
  end

  // bit 0 of the byte address selects a byte inside the word and is dropped.
  always_ff @(posedge CLK) begin
    if (aw_fire) begin
      addr_q  <= awaddr[AXI_ADDR_W-1:1];
      wdata_q <= wdata;
    end else if (ar_fire) begin
      addr_q <= araddr[AXI_ADDR_W-1:1];
    end
    if (both_done && !write_q) begin
      rdata <= {b_rdata, a_rdata};
    end
  end

  assign a_start = start_q;
  assign b_start = start_q;
  assign a_write = write_q;
  assign b_write = write_q;
  assign a_addr  = addr_q;
  assign b_addr  = addr_q;
  assign a_wdata = wdata_q[SRAM_DATA_W-1:0];
  assign b_wdata = wdata_q[WORD_W-1:SRAM_DATA_W];

  // a response, once offered, stays until the master takes it.
  assert property (@(posedge CLK) disable iff (!rst_n) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  assert property (@(posedge CLK) disable iff (!rst_n)
                   rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

endmodule

//--- mem_test_seq.sv
`timescale 1ns/1ns

module mem_test_seq #(
  parameter int NUM_WORDS = 256
) (
  input  logic                    CLK,
  input  logic                    rst_n,

  // AXI4-Lite master
  output logic                    awvalid,
  input  logic                    awready,
  output mem_test_pkg::axi_addr_t awaddr,
  output logic                    wvalid,
  input  logic                    wready,
  output mem_test_pkg::word_t     wdata,
  input  logic                    bvalid,
  output logic                    bready,
  output logic                    arvalid,
  input  logic                    arready,
  output mem_test_pkg::axi_addr_t araddr,
  input  logic                    rvalid,
  output logic                    rready,
  input  mem_test_pkg::word_t     rdata,

  // pass results
  output logic                    test_done,
  output logic                    test_pass,
  output logic [7:0]              err_cnt,
  output logic [7:0]              pass_idx
);
  import mem_test_pkg::*;

  localparam sram_addr_t LAST_IDX = sram_addr_t'(NUM_WORDS - 1);

  seq_state_t state;
  sram_addr_t idx;       // word under test.
  logic       armed;     // low only in the first cycle after reset.
  logic       aw_sent;
  logic       w_sent;
  logic       aw_fire;
  logic       w_fire;
  logic [7:0] err_run;   // mismatches seen so far in this pass.
  logic       resp_owed;

  // valids come straight from the state, so they hold until accepted.
  assign awvalid = armed && state == SEQ_WR_ISSUE && !aw_sent;
  assign wvalid  = armed && state == SEQ_WR_ISSUE && !w_sent;
  assign bready  = (state == SEQ_WR_RESP);
  assign arvalid = (state == SEQ_RD_ISSUE);
  assign rready  = (state == SEQ_RD_DATA);

  assign awaddr = {idx, 1'b0};
  assign araddr = {idx, 1'b0};
  assign wdata  = pattern_word(idx, pass_idx);

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state     <= SEQ_WR_ISSUE;
      idx       <= '0;
      armed     <= 1'b0;
      aw_sent   <= 1'b0;
      w_sent    <= 1'b0;
      err_run   <= '0;
      test_done <= 1'b0;
      test_pass <= 1'b1;
      err_cnt   <= '0;
      pass_idx  <= '0;
    end else begin
      armed     <= 1'b1;
      test_done <= 1'b0;
      case (state)
        SEQ_WR_ISSUE: begin
          // address and data may be accepted in different cycles.
          if (aw_fire) aw_sent <= 1'b1;
          if (w_fire) w_sent <= 1'b1;
          if ((aw_sent || aw_fire) && (w_sent || w_fire)) begin
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
            state   <= SEQ_WR_RESP;
          end
        end
        SEQ_WR_RESP: begin
          if (bvalid) begin
            if (idx == LAST_IDX) begin
              idx   <= '0;
              state <= SEQ_RD_ISSUE;  // all words written, start the read back.
            end else begin
              idx   <= idx + 1'b1;
              state <= SEQ_WR_ISSUE;
            end
          end
        end
        SEQ_RD_ISSUE: begin
          if (arready) state <= SEQ_RD_DATA;
        end
        SEQ_RD_DATA: begin
          if (rvalid) begin
            if (rdata != pattern_word(idx, pass_idx) && err_run != 8'hFF) begin
              err_run <= err_run + 1'b1;
            end
            if (idx == LAST_IDX) begin
              state <= SEQ_REPORT;
            end else begin
              idx   <= idx + 1'b1;
              state <= SEQ_RD_ISSUE;
            end
          end
        end
        SEQ_REPORT: begin
          test_done <= 1'b1;
          test_pass <= (err_run == '0);
          err_cnt   <= err_run;
          err_run   <= '0;
          pass_idx  <= pass_idx + 1'b1;  // wraps, giving 256 patterns.
          idx       <= '0;
          state     <= SEQ_WR_ISSUE;
        end
        default: begin
          state <= SEQ_WR_ISSUE;
        end
      endcase
    end
  end

  // tracks the bus from the handshakes alone, apart from the state machine.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      resp_owed <= 1'b0;
    end else if (aw_fire || (arvalid && arready)) begin
      resp_owed <= 1'b1;
    end else if ((bvalid && bready) || (rvalid && rready)) begin
      resp_owed <= 1'b0;
    end
  end

  // the slave handles one request at a time, so none may overlap a response.
  assert property (@(posedge CLK) disable iff (!rst_n) resp_owed |-> !awvalid && !arvalid)
    else $error("new request raised while a response is outstanding");

endmodule

//--- mem_test_striped_top.sv
`timescale 1ns/1ns

module mem_test_striped_top #(
  parameter int NUM_WORDS = 256
) (
  input  logic                          CLK,
  input  logic                          rst_n,
  output logic                          led_done,
  output logic                          led_fail,
  output logic                          test_done,
  output logic                          test_pass,
  output logic [7:0]                    err_cnt,

  output logic                          sram_a_oe_n,
  output logic                          sram_a_we_n,
  output mem_test_pkg::sram_addr_t      sram_a_addr,
  inout  wire mem_test_pkg::sram_data_t sram_a_data,

  output logic                          sram_b_oe_n,
  output logic                          sram_b_we_n,
  output mem_test_pkg::sram_addr_t      sram_b_addr,
  inout  wire mem_test_pkg::sram_data_t sram_b_data
);
  import mem_test_pkg::*;

  // AXI4-Lite between sequencer and slave.
  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  logic       arvalid, arready, rvalid, rready;
  axi_addr_t  awaddr, araddr;
  word_t      wdata, rdata;

  // slave to chip controllers.
  logic       a_start, a_write, a_done;
  logic       b_start, b_write, b_done;
  sram_addr_t a_addr, b_addr;
  sram_data_t a_wdata, a_rdata, b_wdata, b_rdata;

  logic [7:0] done_cnt;  // number of completed passes.

  mem_test_seq #(
    .NUM_WORDS(NUM_WORDS)
  ) seq_i (
    .CLK(CLK), .rst_n(rst_n),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata),
    .bvalid(bvalid), .bready(bready),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata),
    .test_done(test_done), .test_pass(test_pass), .err_cnt(err_cnt), .pass_idx()
  );

  sram_stripe_axil axil_i (
    .CLK(CLK), .rst_n(rst_n),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata),
    .bvalid(bvalid), .bready(bready),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata),
    .a_start(a_start), .a_write(a_write), .a_addr(a_addr),
    .a_wdata(a_wdata), .a_rdata(a_rdata), .a_done(a_done),
    .b_start(b_start), .b_write(b_write), .b_addr(b_addr),
    .b_wdata(b_wdata), .b_rdata(b_rdata), .b_done(b_done)
  );

  sram_chip_ctrl chip_a_i (
    .CLK(CLK), .rst_n(rst_n),
    .start(a_start), .write(a_write), .addr(a_addr), .wdata(a_wdata),
    .rdata(a_rdata), .done(a_done),
    .sram_oe_n(sram_a_oe_n), .sram_we_n(sram_a_we_n),
    .sram_addr(sram_a_addr), .sram_data(sram_a_data)
  );

  sram_chip_ctrl chip_b_i (
    .CLK(CLK), .rst_n(rst_n),
    .start(b_start), .write(b_write), .addr(b_addr), .wdata(b_wdata),
    .rdata(b_rdata), .done(b_done),
    .sram_oe_n(sram_b_oe_n), .sram_we_n(sram_b_we_n),
    .sram_addr(sram_b_addr), .sram_data(sram_b_data)
  );

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      done_cnt <= '0;
    end else if (test_done) begin
      done_cnt <= done_cnt + 1'b1;
    end
  end

  assign led_done = done_cnt[7];  // toggles every 128 passes, a slow heartbeat.
  assign led_fail = !test_pass;

endmodule

//--- sram_model.sv
`timescale 1ns/1ns

module sram_model (
  input  logic                          oe_n,
  input  logic                          we_n,
  input  mem_test_pkg::sram_addr_t      addr,
  inout  wire mem_test_pkg::sram_data_t data,
  input  logic                          stuck_en,
  input  logic [2:0]                    stuck_bit,
  input  logic                          stuck_val
);
  import mem_test_pkg::*;

  sram_data_t mem [0:(1 << SRAM_ADDR_W)-1];
  sram_data_t rd_byte;  // cell contents as the read path sees them.

  // the chip latches a write on the rising edge of we_n.
  always @(posedge we_n) begin
    mem[addr] <= data;
  end

  // a stuck bit line shows up on every read, whatever was written.
  always_comb begin
    rd_byte = mem[addr];
    if (stuck_en) begin
      rd_byte[stuck_bit] = stuck_val;
    end
  end

  // the chip drives the bus only while it is being read.
  assign data = (!oe_n && we_n) ? rd_byte : 'z;

endmodule

//--- tb_mem_test.sv
`timescale 1ns/1ns

module tb_mem_test;
  import mem_test_pkg::*;

  localparam int NUM_WORDS = 64;
  // about 8 cycles per access, and every word is written once and read once.
  localparam int PASS_CYCLES = NUM_WORDS * 2 * 8;
  localparam int WATCHDOG_CYCLES = 8 * PASS_CYCLES + 2000;

  logic        CLK;
  logic        rst_n;
  logic        a_stuck_en;
  logic        b_stuck_en;
  logic [2:0]  stuck_bit;
  logic        stuck_val;

  logic        led_done;
  logic        led_fail;
  logic        test_done;
  logic        test_pass;
  logic [7:0]  err_cnt;
  logic        a_oe_n;
  logic        a_we_n;
  logic        b_oe_n;
  logic        b_we_n;
  sram_addr_t  a_addr;
  sram_addr_t  b_addr;
  wire sram_data_t a_data;
  wire sram_data_t b_data;

  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;
  int          expected_errs;
  word_t       w;

  mem_test_striped_top #(
    .NUM_WORDS(NUM_WORDS)
  ) dut (
    .CLK(CLK), .rst_n(rst_n),
    .led_done(led_done), .led_fail(led_fail),
    .test_done(test_done), .test_pass(test_pass), .err_cnt(err_cnt),
    .sram_a_oe_n(a_oe_n), .sram_a_we_n(a_we_n), .sram_a_addr(a_addr), .sram_a_data(a_data),
    .sram_b_oe_n(b_oe_n), .sram_b_we_n(b_we_n), .sram_b_addr(b_addr), .sram_b_data(b_data)
  );

  sram_model sram_a (
    .oe_n(a_oe_n), .we_n(a_we_n), .addr(a_addr), .data(a_data),
    .stuck_en(a_stuck_en), .stuck_bit(stuck_bit), .stuck_val(stuck_val)
  );

  sram_model sram_b (
    .oe_n(b_oe_n), .we_n(b_we_n), .addr(b_addr), .data(b_data),
    .stuck_en(b_stuck_en), .stuck_bit(stuck_bit), .stuck_val(stuck_val)
  );

  initial CLK = 1'b0;
  always #5 CLK = !CLK;

  // the expected word is the index times 0x9E37 plus the pass times 0x3C5A, cut to 16 bits.
  function automatic word_t expected_word(input int idx, input int pass);
    int unsigned sum;
    sum = idx * 32'h9E37 + (pass % 256) * 32'h3C5A;
    return sum[15:0];
  endfunction

  task automatic open_test();
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic close_test(input string name);
    if (errors == errors_at_start) begin
      $display("test %0d, %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d, %s: %0d checks failed", tests_run, name, errors - errors_at_start);
    end
  endtask

  // results are sampled on the falling edge, half a cycle after they change.
  task automatic wait_pass_end();
    @(negedge CLK);
    while (!test_done) @(negedge CLK);
  endtask

  task automatic expect_result(input logic pass_exp, input int errs_exp);
    if (test_pass !== pass_exp) begin
      errors++;
      $display("CHECK FAILED at %0t: test_pass is %b, expected %b", $time, test_pass, pass_exp);
    end
    if (err_cnt !== 8'(errs_exp)) begin
      errors++;
      $display("CHECK FAILED at %0t: err_cnt is %0d, expected %0d", $time, err_cnt, errs_exp);
    end
    if (led_fail !== !pass_exp) begin
      errors++;
      $display("CHECK FAILED at %0t: led_fail is %b, expected %b", $time, led_fail, !pass_exp);
    end
  endtask

  // chip A must hold the low byte and chip B the high byte of every word.
  task automatic compare_models(input int pass);
    word_t exp;
    for (int i = 0; i < NUM_WORDS; i++) begin
      exp = expected_word(i, pass);
      if (sram_a.mem[i] !== exp[7:0]) begin
        errors++;
        $display("CHECK FAILED at %0t: chip A word %0d is %h, expected %h",
                 $time, i, sram_a.mem[i], exp[7:0]);
      end
      if (sram_b.mem[i] !== exp[15:8]) begin
        errors++;
        $display("CHECK FAILED at %0t: chip B word %0d is %h, expected %h",
                 $time, i, sram_b.mem[i], exp[15:8]);
      end
    end
  endtask

  initial begin
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    a_stuck_en   = 1'b0;
    b_stuck_en   = 1'b0;
    stuck_bit    = '0;
    stuck_val    = 1'b0;
    void'($urandom(16991));
    repeat (4) @(negedge CLK);

    open_test();
    if (test_done !== 1'b0 || test_pass !== 1'b1 || led_done !== 1'b0) begin
      errors++;
      $display("CHECK FAILED at %0t: status after reset is done %b pass %b led %b",
               $time, test_done, test_pass, led_done);
    end
    if (a_we_n !== 1'b1 || a_oe_n !== 1'b1 || b_we_n !== 1'b1 || b_oe_n !== 1'b1) begin
      errors++;
      $display("CHECK FAILED at %0t: strobes after reset are A %b%b B %b%b",
               $time, a_we_n, a_oe_n, b_we_n, b_oe_n);
    end
    close_test("reset state");
    rst_n = 1'b1;

    open_test();
    wait_pass_end();
    expect_result(1'b1, 0);
    close_test("pass 0 clean");
    open_test();
    compare_models(0);
    close_test("striping after pass 0");

    open_test();
    wait_pass_end();
    expect_result(1'b1, 0);
    close_test("pass 1 clean");
    open_test();
    compare_models(1);
    close_test("pattern of pass 1");

    // pass 2 starts right away, its reads come long after this edge.
    stuck_bit  = 3'($urandom % 8);
    stuck_val  = 1'($urandom % 2);
    b_stuck_en = 1'b1;
    expected_errs = 0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      w = expected_word(i, 2);
      if (w[SRAM_DATA_W + stuck_bit] != stuck_val) expected_errs++;
    end
    open_test();
    wait_pass_end();
    expect_result(expected_errs == 0, expected_errs);
    close_test($sformatf("chip B bit %0d stuck at %0d", stuck_bit, stuck_val));

    b_stuck_en = 1'b0;
    open_test();
    wait_pass_end();
    expect_result(1'b1, 0);
    close_test("recovery after fault release");

    $display("%0d tests run, %0d failed, %0d checks failed", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("watchdog expired after %0d cycles, the tester stopped finishing its passes",
             WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- src.f
mem_test_pkg.sv
sram_chip_ctrl.sv
sram_stripe_axil.sv
mem_test_seq.sv
mem_test_striped_top.sv
sram_model.sv
tb_mem_test.sv

//--- Makefile
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_mem_test: src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_test -f src.f

run: obj_dir/Vtb_mem_test
	@out=$$(./obj_dir/Vtb_mem_test); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf obj_dir
